//--- hw/fir_cfg_pkg.sv
package fir_cfg_pkg;

    // datapath width for samples, coefficients and the accumulator
    localparam int data_width = 32;

    // filter length, fixed by the tap registers
    localparam int num_taps = 11;

    // wide enough for tap and history indices 0 to 10
    localparam int tap_idx_width = 4;

    typedef logic signed [data_width-1:0] data_t;

    typedef logic [tap_idx_width-1:0] tap_idx_t;

    // engine sequence
    // st_clear zeroes the history
    // st_mac walks the 11 taps
    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_intake,
        st_mac,
        st_output
    } engine_state_t;

endpackage

//--- hw/fir_regs_pkg.sv
package fir_regs_pkg;

    localparam int addr_width = 12;

    typedef logic [addr_width-1:0] addr_t;

    // AXI-Lite register map
    localparam addr_t addr_ap_ctrl     = 12'h000;
    localparam addr_t addr_data_length = 12'h010;

    // tap i lives at addr_tap_base + 4*i
    localparam addr_t addr_tap_base    = 12'h020;

    // ap_ctrl bit positions
    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

    // idle set, start and done clear
    localparam logic [2:0] ap_ctrl_reset = 3'h4;

endpackage

//--- hw/fir_sample_ram.sv
`timescale 1ns/1ns

module fir_sample_ram (
    input  logic                  axis_clk,
    input  logic                  wr_en,
    input  fir_cfg_pkg::tap_idx_t wr_idx,
    input  fir_cfg_pkg::data_t    wr_data,
    input  fir_cfg_pkg::tap_idx_t rd_idx,
    output fir_cfg_pkg::data_t    rd_data
);
    import fir_cfg_pkg::*;

    // one word per tap of history
    data_t mem [0:num_taps-1];

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, returns the old word on a same-address write
    always_ff @(posedge axis_clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- hw/fir_axil_regs.sv
`timescale 1ns/1ns

module fir_axil_regs (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  fir_regs_pkg::addr_t   awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  fir_cfg_pkg::data_t    wdata,
    input  logic                  arvalid,
    output logic                  arready,
    input  fir_regs_pkg::addr_t   araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output fir_cfg_pkg::data_t    rdata,
    input  fir_cfg_pkg::tap_idx_t tap_idx,
    input  logic                  busy,
    input  logic                  first_accepted,
    input  logic                  run_done,
    output logic                  start_pulse,
    output fir_cfg_pkg::data_t    data_length,
    output fir_cfg_pkg::data_t    coef
);
    import fir_cfg_pkg::*;
    import fir_regs_pkg::*;

    logic  bus_open;
    logic  ap_start;
    logic  ap_done;
    logic  ap_idle;
    logic  wr_accept;
    logic  rd_accept;
    data_t ap_ctrl_word;
    data_t coef_mem [0:num_taps-1];

    function automatic logic is_tap(input addr_t addr);
        return (addr >= addr_tap_base)
            && (addr < addr_tap_base + addr_t'(4 * num_taps))
            && (addr[1:0] == 2'b00);
    endfunction

    function automatic tap_idx_t tap_of(input addr_t addr);
        addr_t offset;
        offset = addr - addr_tap_base;
        return offset[tap_idx_width+1:2];
    endfunction

    // bus closed while the engine runs or a read waits for rready
    assign awready = bus_open && !busy && !rvalid;
    assign wready  = awready;
    assign arready = awready;

    assign wr_accept = awvalid && wvalid && awready && wready;
    assign rd_accept = arvalid && arready;

    assign start_pulse = wr_accept && (awaddr == addr_ap_ctrl)
                      && wdata[ap_start_bit] && ap_idle;

    // combinational tap lookup for the MAC
    assign coef = (tap_idx < tap_idx_t'(num_taps)) ? coef_mem[tap_idx] : '0;

    always_comb begin
        ap_ctrl_word = '0;
        ap_ctrl_word[ap_start_bit] = ap_start;
        ap_ctrl_word[ap_done_bit]  = ap_done;
        ap_ctrl_word[ap_idle_bit]  = ap_idle;
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            bus_open    <= 1'b0;
            rvalid      <= 1'b0;
            ap_start    <= ap_ctrl_reset[ap_start_bit];
            ap_done     <= ap_ctrl_reset[ap_done_bit];
            ap_idle     <= ap_ctrl_reset[ap_idle_bit];
            data_length <= '0;
        end else begin
            bus_open <= 1'b1;
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // start drops once the first sample is taken
            if (start_pulse) begin
                ap_start <= 1'b1;
            end else if (first_accepted) begin
                ap_start <= 1'b0;
            end
            if (start_pulse) begin
                ap_idle <= 1'b0;
            end else if (run_done) begin
                ap_idle <= 1'b1;
            end
            // done clears when ap_ctrl is read
            if (run_done) begin
                ap_done <= 1'b1;
            end else if (rd_accept && (araddr == addr_ap_ctrl)) begin
                ap_done <= 1'b0;
            end
            if (wr_accept && (awaddr == addr_data_length)) begin
                data_length <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_accept && is_tap(awaddr)) begin
            coef_mem[tap_of(awaddr)] <= wdata;
        end
    end

    // read data captured on the accepting edge
    always_ff @(posedge axis_clk) begin
        if (rd_accept) begin
            if (araddr == addr_ap_ctrl) begin
                rdata <= ap_ctrl_word;
            end else if (araddr == addr_data_length) begin
                rdata <= data_length;
            end else if (is_tap(araddr)) begin
                rdata <= coef_mem[tap_of(araddr)];
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

//--- hw/fir_engine.sv
`timescale 1ns/1ns

module fir_engine (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  start_pulse,
    input  fir_cfg_pkg::data_t    data_length,
    input  fir_cfg_pkg::data_t    coef,
    input  logic                  ss_tvalid,
    output logic                  ss_tready,
    input  fir_cfg_pkg::data_t    ss_tdata,
    output logic                  sm_tvalid,
    input  logic                  sm_tready,
    output fir_cfg_pkg::data_t    sm_tdata,
    output logic                  sm_tlast,
    output fir_cfg_pkg::tap_idx_t tap_idx,
    output logic                  busy,
    output logic                  first_accepted,
    output logic                  run_done
);
    import fir_cfg_pkg::*;

    engine_state_t         state;
    tap_idx_t              step;
    tap_idx_t              head;
    tap_idx_t              rd_ptr;
    logic [data_width-1:0] out_cnt;
    data_t                 acc;
    data_t                 prod;
    logic                  in_accept;
    logic                  out_accept;
    logic                  out_last;
    logic                  wr_en;
    tap_idx_t              wr_idx;
    data_t                 wr_data;
    data_t                 rd_data;

    function automatic tap_idx_t step_back(input tap_idx_t idx);
        if (idx == '0) begin
            return tap_idx_t'(num_taps - 1);
        end
        return idx - 1'b1;
    endfunction

    function automatic tap_idx_t step_fwd(input tap_idx_t idx);
        if (idx == tap_idx_t'(num_taps - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign in_accept  = ss_tvalid && ss_tready;
    assign out_accept = sm_tvalid && sm_tready;
    assign out_last   = (out_cnt + 1'b1) == $unsigned(data_length);

    assign ss_tready = (state == st_intake);
    assign sm_tvalid = (state == st_output);
    assign sm_tdata  = acc;
    assign sm_tlast  = sm_tvalid && out_last;

    // rd_data holds the word read on the previous step
    assign tap_idx = step - 1'b1;

    assign busy           = (state != st_idle);
    assign first_accepted = in_accept && (out_cnt == '0);
    assign run_done       = out_accept && out_last;

    // history write port shared by the clear and the intake
    assign wr_en   = (state == st_clear) || in_accept;
    assign wr_idx  = (state == st_clear) ? step : head;
    assign wr_data = (state == st_clear) ? '0 : ss_tdata;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state   <= st_idle;
            step    <= '0;
            head    <= '0;
            rd_ptr  <= '0;
            out_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_pulse) begin
                        state   <= st_clear;
                        step    <= '0;
                        head    <= '0;
                        out_cnt <= '0;
                    end
                end
                st_clear: begin
                    if (step == tap_idx_t'(num_taps - 1)) begin
                        state <= st_intake;
                    end
                    step <= step + 1'b1;
                end
                st_intake: begin
                    if (in_accept) begin
                        state  <= st_mac;
                        step   <= '0;
                        rd_ptr <= head;
                        head   <= step_fwd(head);
                    end
                end
                st_mac: begin
                    // newest sample first, then backward around the buffer
                    if (step < tap_idx_t'(num_taps)) begin
                        rd_ptr <= step_back(rd_ptr);
                    end
                    if (step == tap_idx_t'(num_taps + 1)) begin
                        state <= st_output;
                    end
                    step <= step + 1'b1;
                end
                st_output: begin
                    if (out_accept) begin
                        out_cnt <= out_cnt + 1'b1;
                        state   <= out_last ? st_idle : st_intake;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // multiply then accumulate, one register stage each
    always_ff @(posedge axis_clk) begin
        if (state == st_mac) begin
            prod <= coef * rd_data;
        end
        if (in_accept) begin
            acc <= '0;
        end else if ((state == st_mac) && (step >= tap_idx_t'(2))) begin
            acc <= acc + prod;
        end
    end

    fir_sample_ram u_sample_ram (
        .axis_clk (axis_clk),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rd_idx   (rd_ptr),
        .rd_data  (rd_data)
    );

endmodule

//--- hw/fir.sv
`timescale 1ns/1ns

module fir (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    // AXI-Lite configuration
    input  logic                awvalid,
    output logic                awready,
    input  fir_regs_pkg::addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  fir_cfg_pkg::data_t  wdata,
    input  logic                arvalid,
    output logic                arready,
    input  fir_regs_pkg::addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output fir_cfg_pkg::data_t  rdata,
    // sample stream in, tlast unused
    input  logic                ss_tvalid,
    output logic                ss_tready,
    input  fir_cfg_pkg::data_t  ss_tdata,
    input  logic                ss_tlast,
    // result stream out
    output logic                sm_tvalid,
    input  logic                sm_tready,
    output fir_cfg_pkg::data_t  sm_tdata,
    output logic                sm_tlast
);
    import fir_cfg_pkg::*;

    logic     start_pulse;
    data_t    data_length;
    data_t    coef;
    tap_idx_t tap_idx;
    logic     busy;
    logic     first_accepted;
    logic     run_done;

    fir_axil_regs u_regs (
        .axis_clk       (axis_clk),
        .axis_rst_n     (axis_rst_n),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .tap_idx        (tap_idx),
        .busy           (busy),
        .first_accepted (first_accepted),
        .run_done       (run_done),
        .start_pulse    (start_pulse),
        .data_length    (data_length),
        .coef           (coef)
    );

    fir_engine u_engine (
        .axis_clk       (axis_clk),
        .axis_rst_n     (axis_rst_n),
        .start_pulse    (start_pulse),
        .data_length    (data_length),
        .coef           (coef),
        .ss_tvalid      (ss_tvalid),
        .ss_tready      (ss_tready),
        .ss_tdata       (ss_tdata),
        .sm_tvalid      (sm_tvalid),
        .sm_tready      (sm_tready),
        .sm_tdata       (sm_tdata),
        .sm_tlast       (sm_tlast),
        .tap_idx        (tap_idx),
        .busy           (busy),
        .first_accepted (first_accepted),
        .run_done       (run_done)
    );

endmodule

//--- testbench/fir_tb_vectors.svh
`ifndef FIR_TB_VECTORS_SVH
`define FIR_TB_VECTORS_SVH

// one row per run
// run_len is the data_length written before start
localparam int num_runs = 2;
localparam int max_len  = 10;

localparam int run_len [0:num_runs-1] = '{10, 6};

// tap 0 multiplies the newest sample
localparam int run_coef [0:num_runs-1][0:10] = '{
    '{0, -10, -9, 23, 56, 63, 56, 23, -9, -10, 0},
    '{100003, -1, 4, 1, -5, 9, 2, -6, 5, 3, -70000}
};

// unused tail entries of the shorter run stay zero
// 250000 * 100003 overflows 32 bits on purpose
localparam int run_samples [0:num_runs-1][0:max_len-1] = '{
    '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10},
    '{-7, 250000, 0, 3000, -3, 42, 0, 0, 0, 0}
};

`endif

//--- testbench/fir_tb.sv
`timescale 1ns/1ns

module fir_tb;
    import fir_cfg_pkg::*;
    import fir_regs_pkg::*;

    `include "fir_tb_vectors.svh"

    logic        axis_clk = 1'b0;
    logic        axis_rst_n;
    logic        awvalid;
    logic        awready;
    addr_t       awaddr;
    logic        wvalid;
    logic        wready;
    data_t       wdata;
    logic        arvalid;
    logic        arready;
    addr_t       araddr;
    logic        rvalid;
    logic        rready;
    data_t       rdata;
    logic        ss_tvalid;
    logic        ss_tready;
    data_t       ss_tdata;
    logic        ss_tlast;
    logic        sm_tvalid;
    logic        sm_tready;
    data_t       sm_tdata;
    logic        sm_tlast;
    logic [31:0] rng_state;
    int          cycle_count;
    int          timeout_cycles;

    fir UUT (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    always #4 axis_clk = ~axis_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge axis_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            report_failure($sformatf("Timeout: the DUT did not finish within %0d cycles",
                timeout_cycles));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // direct form sum, samples before the run count as zero
    function automatic int model_output(input int run, input int n);
        int sum;
        int k;
        sum = 0;
        for (k = 0; k < num_taps; k++) begin
            if (n - k >= 0) begin
                sum += run_coef[run][k] * run_samples[run][n - k];
            end
        end
        return sum;
    endfunction

    task automatic write_reg(input addr_t addr, input data_t data);
        logic taken;
        @(posedge axis_clk);
        #1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        taken   = 1'b0;
        while (!taken) begin
            taken = awready && wready;
            @(posedge axis_clk);
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output data_t data);
        logic taken;
        @(posedge axis_clk);
        #1;
        arvalid = 1'b1;
        araddr  = addr;
        taken   = 1'b0;
        while (!taken) begin
            taken = arready;
            @(posedge axis_clk);
            #1;
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge axis_clk);
            #1;
        end
        data = rdata;
        // rvalid and rdata must hold while rready is low
        @(posedge axis_clk);
        #1;
        assert (rvalid && (rdata == data)) else report_failure($sformatf(
            "Mismatch at %0t: read response not held while rready was low", $time));
        rready = 1'b1;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic check_reg(input addr_t addr, input data_t expected, input string what);
        data_t got;
        read_reg(addr, got);
        assert (got == expected) else report_failure($sformatf(
            "Mismatch at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, expected));
    endtask

    // feeds samples and takes results with random back-pressure
    task automatic stream_run(input int run);
        int    len;
        int    in_idx;
        int    out_idx;
        logic  in_fire;
        logic  out_fire;
        data_t expected;
        len      = run_len[run];
        in_idx   = 0;
        out_idx  = 0;
        in_fire  = 1'b0;
        out_fire = 1'b0;
        while (out_idx < len) begin
            @(posedge axis_clk);
            #1;
            if (in_fire) begin
                in_idx++;
            end
            if (out_fire) begin
                out_idx++;
            end
            if (out_idx < len) begin
                ss_tvalid = (in_idx < len);
                ss_tdata  = (in_idx < len) ? data_t'(run_samples[run][in_idx]) : '0;
                ss_tlast  = (in_idx == len - 1);
                rng_state = xorshift32(rng_state);
                sm_tready = (rng_state[3:2] != 2'b00);
                // a held result is compared again every cycle
                if (sm_tvalid) begin
                    expected = data_t'(model_output(run, out_idx));
                    assert (sm_tdata == expected) else report_failure($sformatf(
                        "Mismatch at %0t: run %0d output %0d is 0x%08h, expected 0x%08h",
                        $time, run, out_idx, sm_tdata, expected));
                    assert (sm_tlast == (out_idx == len - 1)) else report_failure($sformatf(
                        "Mismatch at %0t: run %0d output %0d has tlast %0b",
                        $time, run, out_idx, sm_tlast));
                end
                in_fire  = ss_tvalid && ss_tready;
                out_fire = sm_tvalid && sm_tready;
            end
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;
        assert (!sm_tvalid) else report_failure(
            "The DUT presented another result after the last output of the run");
    endtask

    initial begin
        int r;
        int i;
        awvalid        = 1'b0;
        awaddr         = '0;
        wvalid         = 1'b0;
        wdata          = '0;
        arvalid        = 1'b0;
        araddr         = '0;
        rready         = 1'b0;
        ss_tvalid      = 1'b0;
        ss_tdata       = '0;
        ss_tlast       = 1'b0;
        sm_tready      = 1'b0;
        axis_rst_n     = 1'b0;
        rng_state      = 32'd20;
        cycle_count    = 0;
        timeout_cycles = 2000;
        for (r = 0; r < num_runs; r++) begin
            timeout_cycles += 200 * run_len[r];
        end
        repeat (8) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        assert (!sm_tvalid && !ss_tready && !rvalid && !awready && !wready && !arready)
            else report_failure($sformatf(
                "Mismatch at %0t: valid or ready high after reset", $time));
        check_reg(addr_ap_ctrl, 32'h4, "ap_ctrl after reset");
        for (r = 0; r < num_runs; r++) begin
            for (i = 0; i < num_taps; i++) begin
                write_reg(addr_tap_base + addr_t'(4 * i), data_t'(run_coef[r][i]));
            end
            write_reg(addr_data_length, data_t'(run_len[r]));
            for (i = 0; i < num_taps; i++) begin
                check_reg(addr_tap_base + addr_t'(4 * i), data_t'(run_coef[r][i]),
                    $sformatf("tap %0d", i));
            end
            check_reg(addr_data_length, data_t'(run_len[r]), "data_length");
            check_reg(12'h008, '0, "unmapped 0x008");
            check_reg(12'h04c, '0, "unmapped 0x04c");
            write_reg(addr_ap_ctrl, 32'h1);
            stream_run(r);
            // done and idle, then done cleared by the read
            check_reg(addr_ap_ctrl, 32'h6, "ap_ctrl after run");
            check_reg(addr_ap_ctrl, 32'h4, "ap_ctrl after done read");
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- fir.f
+incdir+testbench
hw/fir_cfg_pkg.sv
hw/fir_regs_pkg.sv
hw/fir_sample_ram.sv
hw/fir_axil_regs.sv
hw/fir_engine.sv
hw/fir.sv
testbench/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f fir.f --top-module fir_tb \
    && ./obj_dir/Vfir_tb | grep -F "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
